//--- fetch_pkg.sv
package fetch_pkg;

    // ----------------------------------------
    // Basic types
    // ----------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // AXI read response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // Cache control FSM
    typedef enum logic [2:0] {
        cs_idle,
        cs_lookup,
        cs_refill,
        cs_respond,
        cs_drain
    } cache_state_e;

    // Refill burst engine
    typedef enum logic [1:0] {
        rs_idle,
        rs_address,
        rs_data
    } refill_state_e;

    localparam addr_t default_reset_pc   = 32'h3000_0000;
    localparam int    default_line_words = 4;
    localparam int    default_set_count  = 16;

endpackage

//--- fetch_pc_unit.sv
`timescale 1ns/1ps

module fetch_pc_unit #(
    parameter fetch_pkg::addr_t reset_pc = fetch_pkg::default_reset_pc
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             fetch_ready,
    output logic             fetch_valid,
    output fetch_pkg::addr_t fetch_pc,
    output fetch_pkg::inst_t fetch_inst,
    output logic             fetch_fault,
    output logic             lookup_req,
    output fetch_pkg::addr_t lookup_pc,
    output logic             flush,
    input  logic             lookup_done,
    input  fetch_pkg::inst_t lookup_inst,
    input  logic             lookup_fault,
    input  logic             cache_idle
);
    import fetch_pkg::*;

    addr_t pc;
    logic  need_q;
    logic  busy_q;
    logic  accept;
    logic  take_done;
    logic  want;
    logic  issue;

    assign accept    = fetch_valid && fetch_ready;
    // A response that lines up with a redirect belongs to the old path
    assign take_done = lookup_done && busy_q && !redirect_valid;
    assign flush     = redirect_valid;
    assign lookup_pc = pc;

    // Hold off while a lookup sent last cycle is still being taken by the cache
    assign want  = need_q || accept || redirect_valid;
    assign issue = want && cache_idle && !(lookup_req && !redirect_valid);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end
    end

    // ----------------------------------------
    // Lookup sequencing
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            need_q     <= 1'b1;
            lookup_req <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            lookup_req <= issue;
            need_q     <= want && !issue;
            if (redirect_valid) begin
                busy_q <= 1'b0;
            end else if (lookup_req) begin
                busy_q <= 1'b1;
            end else if (lookup_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Decode output register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else if (redirect_valid) begin
            fetch_valid <= 1'b0;
        end else if (take_done) begin
            fetch_valid <= 1'b1;
        end else if (accept) begin
            fetch_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take_done) begin
            fetch_pc    <= pc;
            fetch_inst  <= lookup_inst;
            fetch_fault <= lookup_fault;
        end
    end

endmodule

//--- icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store #(
    parameter  int line_words = fetch_pkg::default_line_words,
    parameter  int set_count  = fetch_pkg::default_set_count,
    localparam int index_bits = $clog2(set_count),
    localparam int tag_bits   = 30 - $clog2(line_words) - index_bits
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [index_bits-1:0] read_index,
    input  logic [tag_bits-1:0]   read_tag,
    output logic                  tag_hit,
    input  logic                  write_en,
    input  logic                  write_valid,
    input  logic [index_bits-1:0] write_index,
    input  logic [tag_bits-1:0]   write_tag,
    input  logic                  clear
);

    logic [set_count-1:0] valid_bits;
    logic [tag_bits-1:0]  tag_mem [set_count];
    logic                 valid_q;
    logic [tag_bits-1:0]  stored_q;
    logic [tag_bits-1:0]  compare_q;

    // Flash clear wins over a write in the same cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (clear) begin
            valid_bits <= '0;
        end else if (write_en) begin
            valid_bits[write_index] <= write_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            tag_mem[write_index] <= write_tag;
        end
    end

    // Registered read
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_bits[read_index];
        end
    end

    always_ff @(posedge clock) begin
        stored_q  <= tag_mem[read_index];
        compare_q <= read_tag;
    end

    assign tag_hit = valid_q && (stored_q == compare_q);

endmodule

//--- icache_data_store.sv
`timescale 1ns/1ps

module icache_data_store #(
    parameter  int line_words = fetch_pkg::default_line_words,
    parameter  int set_count  = fetch_pkg::default_set_count,
    localparam int index_bits = $clog2(set_count),
    localparam int word_bits  = $clog2(line_words)
) (
    input  logic                  clock,
    input  logic [index_bits-1:0] read_index,
    input  logic [word_bits-1:0]  read_word,
    output fetch_pkg::inst_t      word_data,
    input  logic                  write_en,
    input  logic [index_bits-1:0] write_index,
    input  logic [word_bits-1:0]  write_word,
    input  fetch_pkg::inst_t      write_data
);
    import fetch_pkg::*;

    inst_t line_mem [set_count*line_words];
    logic  same_word;

    // One word per refill beat
    always_ff @(posedge clock) begin
        if (write_en) begin
            line_mem[{write_index, write_word}] <= write_data;
        end
    end

    assign same_word = write_en && (write_index == read_index) && (write_word == read_word);

    // Registered read, passes the beat being written straight through
    always_ff @(posedge clock) begin
        if (same_word) begin
            word_data <= write_data;
        end else begin
            word_data <= line_mem[{read_index, read_word}];
        end
    end

endmodule

//--- icache_refill.sv
`timescale 1ns/1ps

module icache_refill #(
    parameter  int line_words = fetch_pkg::default_line_words,
    localparam int word_bits  = $clog2(line_words)
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 refill_start,
    input  fetch_pkg::addr_t     refill_addr,
    output logic                 arvalid,
    input  logic                 arready,
    output fetch_pkg::addr_t     araddr,
    input  logic                 rvalid,
    input  fetch_pkg::inst_t     rdata,
    input  fetch_pkg::axi_resp_e rresp,
    input  logic                 rlast,
    output logic                 beat_write,
    output logic [word_bits-1:0] beat_word,
    output fetch_pkg::inst_t     beat_data,
    output logic                 refill_done,
    output logic                 refill_error
);
    import fetch_pkg::*;

    localparam int line_lsb = word_bits + 2;

    refill_state_e        state;
    addr_t                addr_q;
    logic [word_bits-1:0] beat_count;
    logic                 error_q;
    logic                 beat_bad;

    // ----------------------------------------
    // Burst FSM
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= rs_idle;
        end else begin
            case (state)
                rs_idle: begin
                    if (refill_start) begin
                        state <= rs_address;
                    end
                end
                rs_address: begin
                    if (arready) begin
                        state <= rs_data;
                    end
                end
                rs_data: begin
                    // Memory returns exactly one line, rlast closes it
                    if (rvalid && rlast) begin
                        state <= rs_idle;
                    end
                end
                default: begin
                    state <= rs_idle;
                end
            endcase
        end
    end

    // Line-aligned burst address
    always_ff @(posedge clock) begin
        if ((state == rs_idle) && refill_start) begin
            addr_q <= {refill_addr[31:line_lsb], {line_lsb{1'b0}}};
        end
    end

    assign beat_bad = (rresp != resp_okay);

    // Beat counter and sticky error
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            beat_count <= '0;
            error_q    <= 1'b0;
        end else if ((state == rs_address) && arready) begin
            beat_count <= '0;
            error_q    <= 1'b0;
        end else if ((state == rs_data) && rvalid) begin
            beat_count <= beat_count + 1'b1;
            error_q    <= error_q || beat_bad;
        end
    end

    assign arvalid      = (state == rs_address);
    assign araddr       = addr_q;
    assign beat_write   = (state == rs_data) && rvalid;
    assign beat_word    = beat_count;
    assign beat_data    = rdata;
    assign refill_done  = beat_write && rlast;
    // Include the last beat's own response
    assign refill_error = error_q || beat_bad;

endmodule

//--- icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int line_words = fetch_pkg::default_line_words,
    parameter int set_count  = fetch_pkg::default_set_count
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 lookup_req,
    input  fetch_pkg::addr_t     lookup_pc,
    input  logic                 flush,
    input  logic                 fence_i,
    output logic                 lookup_done,
    output fetch_pkg::inst_t     lookup_inst,
    output logic                 lookup_fault,
    output logic                 cache_idle,
    output logic                 arvalid,
    input  logic                 arready,
    output fetch_pkg::addr_t     araddr,
    input  logic                 rvalid,
    input  fetch_pkg::inst_t     rdata,
    input  fetch_pkg::axi_resp_e rresp,
    input  logic                 rlast
);
    import fetch_pkg::*;

    localparam int word_bits  = $clog2(line_words);
    localparam int index_bits = $clog2(set_count);
    localparam int line_lsb   = word_bits + 2;
    localparam int tag_lsb    = line_lsb + index_bits;

    cache_state_e         state;
    addr_t                pc_q;
    addr_t                read_addr;
    addr_t                refill_addr;
    logic                 resp_fault_q;
    logic                 tag_hit;
    logic                 tag_mark;
    inst_t                word_data;
    logic                 refill_start;
    logic                 refill_done;
    logic                 refill_error;
    logic                 beat_write;
    logic [word_bits-1:0] beat_word;
    inst_t                beat_data;

    // Stores follow the incoming PC only while idle
    assign read_addr    = (state == cs_idle) ? lookup_pc : pc_q;
    assign refill_start = (state == cs_lookup) && !flush && !tag_hit;
    assign refill_addr  = {pc_q[31:line_lsb], {line_lsb{1'b0}}};
    assign tag_mark     = (state == cs_refill) && refill_done && !refill_error
                          && !flush && !fence_i;

    assign cache_idle   = (state == cs_idle);
    assign lookup_done  = (state == cs_respond) && !flush;
    assign lookup_fault = resp_fault_q;
    assign lookup_inst  = resp_fault_q ? '0 : word_data;

    always_ff @(posedge clock) begin
        if ((state == cs_idle) && lookup_req) begin
            pc_q <= lookup_pc;
        end
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= cs_idle;
            resp_fault_q <= 1'b0;
        end else begin
            case (state)
                cs_idle: begin
                    if (lookup_req && !flush) begin
                        state <= cs_lookup;
                    end
                end
                cs_lookup: begin
                    if (flush) begin
                        state <= cs_idle;
                    end else if (tag_hit) begin
                        resp_fault_q <= 1'b0;
                        state        <= cs_respond;
                    end else begin
                        state <= cs_refill;
                    end
                end
                cs_refill: begin
                    // Burst keeps running to rlast, answer is dropped
                    if (flush || fence_i) begin
                        state <= refill_done ? cs_idle : cs_drain;
                    end else if (refill_done) begin
                        resp_fault_q <= refill_error;
                        state        <= cs_respond;
                    end
                end
                cs_drain: begin
                    if (refill_done) begin
                        state <= cs_idle;
                    end
                end
                default: begin
                    state <= cs_idle;
                end
            endcase
        end
    end

    // Set is invalid while its line is rewritten
    icache_tag_store #(
        .line_words(line_words),
        .set_count (set_count)
    ) tag_store_i (
        .clock      (clock),
        .reset      (reset),
        .read_index (read_addr[tag_lsb-1:line_lsb]),
        .read_tag   (read_addr[31:tag_lsb]),
        .tag_hit    (tag_hit),
        .write_en   (refill_start || tag_mark),
        .write_valid(tag_mark),
        .write_index(pc_q[tag_lsb-1:line_lsb]),
        .write_tag  (pc_q[31:tag_lsb]),
        .clear      (fence_i)
    );

    icache_data_store #(
        .line_words(line_words),
        .set_count (set_count)
    ) data_store_i (
        .clock      (clock),
        .read_index (read_addr[tag_lsb-1:line_lsb]),
        .read_word  (read_addr[line_lsb-1:2]),
        .word_data  (word_data),
        .write_en   (beat_write),
        .write_index(pc_q[tag_lsb-1:line_lsb]),
        .write_word (beat_word),
        .write_data (beat_data)
    );

    icache_refill #(
        .line_words(line_words)
    ) refill_i (
        .clock       (clock),
        .reset       (reset),
        .refill_start(refill_start),
        .refill_addr (refill_addr),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .beat_write  (beat_write),
        .beat_word   (beat_word),
        .beat_data   (beat_data),
        .refill_done (refill_done),
        .refill_error(refill_error)
    );

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t reset_pc   = fetch_pkg::default_reset_pc,
    parameter int               line_words = fetch_pkg::default_line_words,
    parameter int               set_count  = fetch_pkg::default_set_count
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 redirect_valid,
    input  fetch_pkg::addr_t     redirect_pc,
    input  logic                 fence_i,
    input  logic                 fetch_ready,
    output logic                 fetch_valid,
    output fetch_pkg::addr_t     fetch_pc,
    output fetch_pkg::inst_t     fetch_inst,
    output logic                 fetch_fault,
    output logic                 arvalid,
    input  logic                 arready,
    output fetch_pkg::addr_t     araddr,
    input  logic                 rvalid,
    input  fetch_pkg::inst_t     rdata,
    input  fetch_pkg::axi_resp_e rresp,
    input  logic                 rlast
);
    import fetch_pkg::*;

    // PC unit to cache
    logic  lookup_req;
    addr_t lookup_pc;
    logic  flush;
    logic  lookup_done;
    inst_t lookup_inst;
    logic  lookup_fault;
    logic  cache_idle;

    fetch_pc_unit #(
        .reset_pc(reset_pc)
    ) pc_unit_i (
        .clock         (clock),
        .reset         (reset),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .fetch_ready   (fetch_ready),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_inst    (fetch_inst),
        .fetch_fault   (fetch_fault),
        .lookup_req    (lookup_req),
        .lookup_pc     (lookup_pc),
        .flush         (flush),
        .lookup_done   (lookup_done),
        .lookup_inst   (lookup_inst),
        .lookup_fault  (lookup_fault),
        .cache_idle    (cache_idle)
    );

    icache #(
        .line_words(line_words),
        .set_count (set_count)
    ) icache_i (
        .clock       (clock),
        .reset       (reset),
        .lookup_req  (lookup_req),
        .lookup_pc   (lookup_pc),
        .flush       (flush),
        .fence_i     (fence_i),
        .lookup_done (lookup_done),
        .lookup_inst (lookup_inst),
        .lookup_fault(lookup_fault),
        .cache_idle  (cache_idle),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast)
    );

endmodule

//--- tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int line_words   = default_line_words;
    localparam int set_count    = default_set_count;
    localparam int line_lsb     = $clog2(line_words) + 2;
    localparam int tag_lsb      = line_lsb + $clog2(set_count);
    localparam int beat_target  = 600;
    localparam int beat_timeout = 200;

    logic      clock;
    logic      reset;
    logic      redirect_valid;
    addr_t     redirect_pc;
    logic      fence_i;
    logic      fetch_ready;
    logic      fetch_valid;
    addr_t     fetch_pc;
    inst_t     fetch_inst;
    logic      fetch_fault;
    logic      arvalid;
    logic      arready;
    addr_t     araddr;
    logic      rvalid;
    inst_t     rdata;
    axi_resp_e rresp;
    logic      rlast;

    // ----------------------------------------
    // Reference model and responder state
    // ----------------------------------------
    logic [31:0] rng_state;
    logic        model_valid [set_count];
    logic [31:0] model_tag   [set_count];
    addr_t       exp_pc;
    logic [31:0] epoch;
    logic        pred_hit;
    logic        from_accept;
    int          accept_edge;
    int          ar_count;
    int          cycle;
    int          last_rise;
    int          beats;
    int          hits;
    int          misses;
    int          faults;
    int          redirects;
    int          fences;
    logic        fv_prev;
    logic        av_prev;
    logic        redirect_prev;
    logic        in_burst;
    logic        burst_err;
    logic        burst_flushed;
    addr_t       burst_addr;
    int          beat_k;
    int          ar_delay;

    fetch_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .fence_i       (fence_i),
        .fetch_ready   (fetch_ready),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_inst    (fetch_inst),
        .fetch_fault   (fetch_fault),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rresp         (rresp),
        .rlast         (rlast)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Memory contents change with every epoch
    function automatic inst_t data_hash(input addr_t a, input logic [31:0] ep);
        logic [31:0] h;
        h = a ^ (ep * 32'h9e37_79b9);
        h = h ^ (h >> 15);
        h = h * 32'h2c1b_3c6d;
        h = h ^ (h >> 12);
        return h;
    endfunction

    function automatic logic line_is_bad(input addr_t a);
        return ((a >> line_lsb) % 11) == 5;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[31:line_lsb], {line_lsb{1'b0}}};
    endfunction

    function automatic int set_of(input addr_t a);
        return int'((a >> line_lsb) % set_count);
    endfunction

    function automatic logic model_holds(input addr_t a);
        return model_valid[set_of(a)] && (model_tag[set_of(a)] == (a >> tag_lsb));
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        stop_run();
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_fault(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // One falling edge: observe, check, then drive the next inputs
    task automatic run_cycle();
        logic  fv;
        logic  av;
        logic  do_redirect;
        logic  do_fence;
        logic  bad_beat;
        addr_t target;

        fv = fetch_valid;
        av = arvalid;

        // Retire what was driven on the last falling edge
        if (arready) begin
            in_burst  = 1'b1;
            beat_k    = 0;
            burst_err = 1'b0;
        end
        if (rvalid) begin
            if (rlast) begin
                in_burst = 1'b0;
            end else begin
                beat_k++;
            end
        end

        if (redirect_prev && fv) begin
            report_failure("fetch_valid still high on the cycle after a redirect");
        end

        // Held beats must not move, so compare every cycle
        if (fv) begin
            check_addr("fetch_pc", fetch_pc, exp_pc);
            check_fault("fetch_fault", fetch_fault, line_is_bad(exp_pc));
            check_inst("fetch_inst", fetch_inst,
                       line_is_bad(exp_pc) ? 32'h0 : data_hash(exp_pc, epoch));
            if (!fv_prev) begin
                if (ar_count != (pred_hit ? 0 : 1)) begin
                    report_failure("wrong number of AR requests for this fetch");
                end
                // Taken on the edge after the decision, seen one falling edge late
                if (pred_hit && from_accept && (cycle - accept_edge != 4)) begin
                    report_failure("hit did not reach decode 3 cycles after the accepted beat");
                end
                last_rise = cycle;
                if (pred_hit) begin
                    hits++;
                end else begin
                    misses++;
                end
                if (line_is_bad(exp_pc)) begin
                    faults++;
                end
            end
        end

        if (av && !av_prev) begin
            if (fv) begin
                report_failure("AR issued while a beat waits at decode");
            end
            check_addr("araddr", araddr, line_of(exp_pc));
            if (model_holds(exp_pc)) begin
                report_failure("AR issued for a line the model holds as valid");
            end
            // Refill start drops the set's valid bit
            model_valid[set_of(araddr)] = 1'b0;
            ar_count++;
            burst_flushed = 1'b0;
            ar_delay = int'(next_rand() % 4);
        end

        // ----------------------------------------
        // Decode side and redirects
        // ----------------------------------------
        do_redirect = (next_rand() % 32) == 0;
        do_fence    = do_redirect && ((next_rand() % 4) == 0);
        target      = default_reset_pc + (next_rand() & 32'h0000_03fc);
        fetch_ready = do_redirect ? 1'b0 : ((next_rand() % 4) != 0);

        redirect_valid = do_redirect;
        redirect_pc    = target;
        fence_i        = do_fence;
        if (do_redirect) begin
            exp_pc = target;
            redirects++;
            if (av || in_burst) begin
                burst_flushed = 1'b1;
            end
            if (do_fence) begin
                epoch++;
                fences++;
                for (int s = 0; s < set_count; s++) begin
                    model_valid[s] = 1'b0;
                end
            end
            pred_hit    = model_holds(target);
            ar_count    = 0;
            from_accept = 1'b0;
        end

        if (fv && fetch_ready) begin
            exp_pc      = exp_pc + 32'd4;
            pred_hit    = model_holds(exp_pc);
            ar_count    = 0;
            from_accept = 1'b1;
            accept_edge = cycle;
            beats++;
        end

        // AXI memory responder
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rresp   = resp_okay;
        if (in_burst) begin
            if ((next_rand() % 3) != 0) begin
                bad_beat  = line_is_bad(burst_addr) && (beat_k == 1);
                rvalid    = 1'b1;
                rdata     = data_hash(burst_addr + addr_t'(4 * beat_k), epoch);
                rresp     = bad_beat ? resp_slverr : resp_okay;
                rlast     = (beat_k == line_words - 1);
                burst_err = burst_err || bad_beat;
                if (rlast && !burst_err && !burst_flushed) begin
                    model_valid[set_of(burst_addr)] = 1'b1;
                    model_tag[set_of(burst_addr)]   = burst_addr >> tag_lsb;
                end
            end
        end else if (av) begin
            if (ar_delay == 0) begin
                arready    = 1'b1;
                burst_addr = araddr;
            end else begin
                ar_delay--;
            end
        end

        fv_prev       = fv;
        av_prev       = av;
        redirect_prev = do_redirect;
    endtask

    initial begin
        rng_state      = 32'hb90d_1fa8;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        fence_i        = 1'b0;
        fetch_ready    = 1'b0;
        arready        = 1'b0;
        rvalid         = 1'b0;
        rdata          = '0;
        rresp          = resp_okay;
        rlast          = 1'b0;
        for (int s = 0; s < set_count; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        exp_pc        = default_reset_pc;
        epoch         = '0;
        pred_hit      = 1'b0;
        from_accept   = 1'b0;
        accept_edge   = 0;
        ar_count      = 0;
        cycle         = 0;
        last_rise     = 0;
        beats         = 0;
        hits          = 0;
        misses        = 0;
        faults        = 0;
        redirects     = 0;
        fences        = 0;
        fv_prev       = 1'b0;
        av_prev       = 1'b0;
        redirect_prev = 1'b0;
        in_burst      = 1'b0;
        burst_err     = 1'b0;
        burst_flushed = 1'b0;
        burst_addr    = '0;
        beat_k        = 0;
        ar_delay      = 0;

        repeat (5) begin
            @(negedge clock);
            if (fetch_valid !== 1'b0 || arvalid !== 1'b0) begin
                report_failure("fetch_valid or arvalid high during reset");
            end
        end
        reset = 1'b0;

        while (beats < beat_target) begin
            @(negedge clock);
            cycle++;
            run_cycle();
            if (cycle - last_rise > beat_timeout) begin
                report_failure("no beat reached decode within the timeout");
            end
        end

        $display("beats %0d hits %0d misses %0d faults %0d redirects %0d fences %0d",
                 beats, hits, misses, faults, redirects, fences);
        // Every kind of fetch must have been seen at least once
        if (hits == 0 || misses == 0 || faults == 0 || redirects == 0 || fences == 0) begin
            report_failure("run did not exercise hits, misses, faults, redirects and fences");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- vlog.f
fetch_pkg.sv
fetch_pc_unit.sv
icache_tag_store.sv
icache_data_store.sv
icache_refill.sv
icache.sv
fetch_top.sv
tb_fetch_top.sv
